/* qr_frontend_top.f */
+incdir+src
src/qr_pixel_pkg.sv
src/qr_mem_pkg.sv
src/bit_ram_if.sv
src/bit_frame_ram.sv
src/pixel_binarizer.sv
src/majority_filter.sv
src/decode_ctrl.sv
src/qr_frontend_top.sv
verif/tb_qr_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the qr front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f qr_frontend_top.f --top-module tb_qr_frontend \
  --Mdir obj_dir -o tb_qr_frontend

./obj_dir/tb_qr_frontend > sim.log 2>&1
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported errors"
  exit 1
fi

/* verif/tb_qr_frontend.sv */
`include "qr_consts.svh"

module tb_qr_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ST_STREAM = 0;
  localparam int ST_AVG    = 1;
  localparam int ST_FIN    = 2;
  // all cycles outside the filter pass, pixels plus reads plus resets
  localparam int STREAM_CYC  = 1000 + 6 * (`PIX_N + 8) + 3 * 20;
  localparam int FILT_CYC    = 9 * `PIX_N;
  localparam int WATCHDOG_NS = 4 * 2 * (STREAM_CYC + FILT_CYC) + 400;

  logic                 clk_pixel;
  logic                 sys_rst;
  logic                 pix_valid;
  logic [`PIX_W-1:0]    pix_data;
  logic [`X_W-1:0]      pix_x;
  logic [`Y_W-1:0]      pix_y;
  logic [`THRESH_W-1:0] thresh;
  logic                 capture;
  logic                 start;
  logic                 view_en;
  logic [`ADDR_W-1:0]   view_addr;
  logic                 view_sel;
  logic                 view_pixel;
  logic                 view_valid;
  logic                 decode_busy;
  logic                 decode_done;

  logic        fb_model [`PIX_N];   // expected frame buffer bits
  logic        res_model [`PIX_N];  // expected filtered bits
  logic        exp_vld [2];         // display requests in flight, [1] is due now
  logic        exp_pix [2];
  logic [31:0] rng_state;
  int          exp_state;
  int          err_cnt;
  int          check_cnt;

  qr_frontend_top qr_frontend_top_i (.*);

  always #2 clk_pixel = ~clk_pixel;  // 4 ns period

  function automatic logic [31:0] xorshift32();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // 5-6-5 widened to 8 bits per channel, gray = (r + 2g + b) / 4
  function automatic logic binarize(input logic [15:0] px, input logic [7:0] thr);
    int r8;
    int g8;
    int b8;
    int gray;
    r8   = int'(px[15:11]) * 8;
    g8   = int'(px[10:5]) * 4;
    b8   = int'(px[4:0]) * 8;
    gray = (r8 + 2 * g8 + b8) / 4;
    return gray > int'(thr);
  endfunction

  // 3x3 majority of the frozen frame, neighbours off the edge are zero
  function automatic void build_majority();
    int cnt;
    int nx;
    int ny;
    for (int y = 0; y < `IMG_H; y++) begin
      for (int x = 0; x < `IMG_W; x++) begin
        cnt = 0;
        for (int dy = -1; dy <= 1; dy++) begin
          for (int dx = -1; dx <= 1; dx++) begin
            nx = x + dx;
            ny = y + dy;
            if (nx >= 0 && nx < `IMG_W && ny >= 0 && ny < `IMG_H && fb_model[nx + `IMG_W * ny])
              cnt++;
          end
        end
        res_model[x + `IMG_W * y] = (cnt >= `MAJORITY);
      end
    end
  endfunction

  // display rule, blank while averaging or on the stale result buffer
  function automatic logic expected_view(input logic sel, input int addr);
    if (exp_state == ST_AVG) return 1'b0;
    if (sel && exp_state == ST_STREAM) return 1'b0;
    return sel ? res_model[addr] : fb_model[addr];
  endfunction

  task automatic check_value(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_status(input logic busy, input logic done);
    check_value("decode_busy", busy, decode_busy);
    check_value("decode_done", done, decode_done);
  endtask

  // one falling edge, checks the display pipe and drops view_en
  task automatic tick();
    @(negedge clk_pixel);
    check_value("view_valid", exp_vld[1], view_valid);
    if (exp_vld[1]) check_value("view_pixel", exp_pix[1], view_pixel);
    exp_vld[1] = exp_vld[0];
    exp_pix[1] = exp_pix[0];
    exp_vld[0] = 1'b0;
    exp_pix[0] = 1'b0;
    view_en    = 1'b0;
  endtask

  task automatic drive_view(input int addr, input logic sel);
    view_en    = 1'b1;
    view_addr  = addr[`ADDR_W-1:0];
    view_sel   = sel;
    exp_vld[0] = 1'b1;               // due two edges later
    exp_pix[0] = expected_view(sel, addr);
  endtask

  task automatic apply_reset();
    tick();
    sys_rst = 1'b1;
    repeat (16) tick();
    sys_rst   = 1'b0;
    capture   = 1'b0;
    start     = 1'b0;
    exp_state = ST_STREAM;
  endtask

  // random pixels, some off the image, some not strobed
  task automatic stream_pixels(input int n, input logic cap);
    logic [31:0] r;
    logic [31:0] q;
    logic [31:0] s;
    int          xi;
    int          yi;
    tick();
    capture = cap;
    for (int i = 0; i < n; i++) begin
      tick();
      r  = xorshift32();
      q  = xorshift32();
      s  = xorshift32();
      xi = int'(r[7:0]) % (`IMG_W + 3);
      yi = int'(r[15:8]) % (`IMG_H + 3);
      if (s[29:27] == 3'd0) xi = int'(s[20:10]);   // far column
      if (s[31:30] == 2'd0) yi = int'(s[9:0]);     // far row
      pix_valid = (q[27:24] != 4'd0);
      pix_data  = q[15:0];
      thresh    = q[23:16];
      pix_x     = `X_W'(xi);
      pix_y     = `Y_W'(yi);
      if (pix_valid && !cap && exp_state == ST_STREAM && xi < `IMG_W && yi < `IMG_H)
        fb_model[xi + `IMG_W * yi] = binarize(pix_data, thresh);
    end
    tick();
    pix_valid = 1'b0;
    repeat (2) tick();   // last write lands before any read
  endtask

  task automatic read_all(input logic sel);
    for (int a = 0; a < `PIX_N; a++) begin
      tick();
      drive_view(a, sel);
    end
    repeat (3) tick();
  endtask

  task automatic spot_reads(input int n, input logic sel);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      tick();
      r = xorshift32();
      drive_view(int'(r[15:0]) % `PIX_N, sel);
    end
    repeat (3) tick();
  endtask

  task automatic run_decode();
    logic [31:0] r;
    tick();
    capture = 1'b1;
    start   = 1'b1;
    build_majority();
    exp_state = ST_AVG;   // taken at the next rising edge
    tick();
    start = 1'b0;
    check_status(1'b1, 1'b0);
    tick();
    while (!decode_done) begin
      check_value("decode_busy", 1'b1, decode_busy);
      r = xorshift32();
      if (r[0]) drive_view(int'(r[15:8]) % `PIX_N, r[16]);  // must read 0
      tick();
    end
    exp_state = ST_FIN;
    check_value("decode_busy", 1'b0, decode_busy);  // drops with done
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: no end of test after %0d ns, the run timed out", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    clk_pixel = 1'b0;
    sys_rst   = 1'b1;
    pix_valid = 1'b0;
    pix_data  = '0;
    pix_x     = '0;
    pix_y     = '0;
    thresh    = '0;
    capture   = 1'b0;
    start     = 1'b0;
    view_en   = 1'b0;
    view_addr = '0;
    view_sel  = 1'b0;
    exp_vld[0] = 1'b0;
    exp_vld[1] = 1'b0;
    exp_pix[0] = 1'b0;
    exp_pix[1] = 1'b0;
    for (int i = 0; i < `PIX_N; i++) begin
      fb_model[i]  = 1'b0;   // buffers power up clear
      res_model[i] = 1'b0;
    end
    rng_state = 32'h9918_dfea;
    exp_state = ST_STREAM;
    err_cnt   = 0;
    check_cnt = 0;

    apply_reset();
    tick();
    check_status(1'b0, 1'b0);
    check_value("view_pixel", 1'b0, view_pixel);
    spot_reads(32, 1'b1);          // result buffer blanked while streaming

    stream_pixels(600, 1'b0);
    read_all(1'b0);
    stream_pixels(200, 1'b1);      // frozen, model stays as is
    read_all(1'b0);

    run_decode();
    read_all(1'b1);
    read_all(1'b0);
    check_status(1'b0, 1'b1);

    apply_reset();                 // back to streaming, buffers keep contents
    tick();
    check_status(1'b0, 1'b0);
    stream_pixels(200, 1'b0);
    read_all(1'b0);
    spot_reads(16, 1'b1);

    repeat (4) tick();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src/qr_frontend_top.sv */
`include "qr_consts.svh"

// binarize, freeze, 3x3 majority, with a display read port on both buffers
module qr_frontend_top (
  input  logic                 clk_pixel,
  input  logic                 sys_rst,
  input  logic                 pix_valid,
  input  logic [`PIX_W-1:0]    pix_data,    // rgb 5-6-5
  input  logic [`X_W-1:0]      pix_x,
  input  logic [`Y_W-1:0]      pix_y,
  input  logic [`THRESH_W-1:0] thresh,
  input  logic                 capture,     // freezes the frame buffer
  input  logic                 start,       // with capture, starts the filter
  input  logic                 view_en,
  input  logic [`ADDR_W-1:0]   view_addr,
  input  logic                 view_sel,
  output logic                 view_pixel,
  output logic                 view_valid,
  output logic                 decode_busy,
  output logic                 decode_done
);

  logic               store_en;
  logic               filt_start;
  logic               filt_done;
  logic               filt_rd_en;
  logic [`ADDR_W-1:0] filt_rd_addr;
  logic               filt_rd_data;

  bit_ram_if fb_if ();    // binarized camera frame
  bit_ram_if res_if ();   // filtered image

  bit_frame_ram frame_buffer (
    .clk_pixel (clk_pixel),
    .ram       (fb_if.mem)
  );

  bit_frame_ram result_buffer (
    .clk_pixel (clk_pixel),
    .ram       (res_if.mem)
  );

  pixel_binarizer pixel_binarizer_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .thresh    (thresh),
    .store_en  (store_en),
    .fb        (fb_if.writer)
  );

  majority_filter majority_filter_i (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .start_pulse  (filt_start),
    .filt_rd_en   (filt_rd_en),
    .filt_rd_addr (filt_rd_addr),
    .filt_rd_data (filt_rd_data),
    .res          (res_if.writer),
    .done         (filt_done)
  );

  decode_ctrl decode_ctrl_i (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .capture      (capture),
    .start        (start),
    .filt_done    (filt_done),
    .filt_start   (filt_start),
    .store_en     (store_en),
    .fb           (fb_if.reader),
    .res          (res_if.reader),
    .filt_rd_en   (filt_rd_en),
    .filt_rd_addr (filt_rd_addr),
    .filt_rd_data (filt_rd_data),
    .view_en      (view_en),
    .view_addr    (view_addr),
    .view_sel     (view_sel),
    .view_pixel   (view_pixel),
    .view_valid   (view_valid),
    .decode_busy  (decode_busy),
    .decode_done  (decode_done)
  );

endmodule

/* src/decode_ctrl.sv */
`include "qr_consts.svh"

// decode sequence and read port sharing between display and filter
module decode_ctrl (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  logic                  capture,
  input  logic                  start,
  input  logic                  filt_done,
  output logic                  filt_start,
  output logic                  store_en,
  bit_ram_if.reader             fb,
  bit_ram_if.reader             res,
  input  logic                  filt_rd_en,
  input  qr_mem_pkg::pix_addr_t filt_rd_addr,
  output logic                  filt_rd_data,
  input  logic                  view_en,
  input  qr_mem_pkg::pix_addr_t view_addr,
  input  logic                  view_sel,      // 0 frame buffer, 1 result buffer
  output logic                  view_pixel,
  output logic                  view_valid,
  output logic                  decode_busy,
  output logic                  decode_done
);
  import qr_mem_pkg::*;

  decode_state_e      state;
  decode_state_e      state_nxt;
  logic               go;
  logic               blank_now;
  logic [`RD_LAT-1:0] vld_pipe;
  logic [`RD_LAT-1:0] sel_pipe;
  logic [`RD_LAT-1:0] blank_pipe;   // request made while blanked

  assign go = capture && start;

  always_comb begin
    state_nxt = state;
    case (state)
      STREAMING: if (go) state_nxt = AVERAGING;
      AVERAGING: if (filt_done) state_nxt = FINISHED;
      default:   state_nxt = FINISHED;   // held until reset
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state      <= STREAMING;
      filt_start <= 1'b0;
    end else begin
      state      <= state_nxt;
      filt_start <= (state == STREAMING) && go;  // first AVERAGING cycle
    end
  end

  assign store_en    = (state == STREAMING) && !capture;
  assign decode_busy = (state == AVERAGING);
  assign decode_done = (state == FINISHED);

  // frame buffer read port belongs to the filter while averaging
  assign fb.rd_en      = (state == AVERAGING) ? filt_rd_en : view_en;
  assign fb.rd_addr    = (state == AVERAGING) ? filt_rd_addr : view_addr;
  assign filt_rd_data  = fb.rd_data;
  assign res.rd_en     = view_en;
  assign res.rd_addr   = view_addr;

  // averaging steals the port, stale result buffer before the first pass
  assign blank_now = (state == AVERAGING) || (view_sel && state == STREAMING);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`RD_LAT-2:0], view_en};
    end
  end

  always_ff @(posedge clk_pixel) begin
    sel_pipe   <= {sel_pipe[`RD_LAT-2:0], view_sel};
    blank_pipe <= {blank_pipe[`RD_LAT-2:0], blank_now};
  end

  assign view_valid = vld_pipe[`RD_LAT-1];
  assign view_pixel = vld_pipe[`RD_LAT-1] && !blank_pipe[`RD_LAT-1]
                   && (state != AVERAGING)
                   && (sel_pipe[`RD_LAT-1] ? res.rd_data : fb.rd_data);

endmodule

/* src/majority_filter.sv */
`include "qr_consts.svh"

// 3x3 majority over the frozen frame buffer, one neighbour per cycle
module majority_filter (
  input  logic                  clk_pixel,
  input  logic                  sys_rst,
  input  logic                  start_pulse,
  output logic                  filt_rd_en,
  output qr_mem_pkg::pix_addr_t filt_rd_addr,
  input  logic                  filt_rd_data,
  bit_ram_if.writer             res,
  output logic                  done
);
  import qr_mem_pkg::*;

  logic      active;     // walker running
  logic [3:0] k;         // neighbour 0..8, row major from top left
  pix_addr_t x;          // centre column
  pix_addr_t y;          // centre row
  pix_addr_t ctr;        // centre linear address
  logic      at_left;
  logic      at_right;
  logic      at_top;
  logic      at_bot;
  logic      last_pix;
  logic      col_ok;
  logic      row_ok;
  pix_addr_t col_off;
  pix_addr_t row_off;

  // tags ride alongside the read, index RD_LAT-1 lines up with rd_data
  logic [`RD_LAT-1:0] tag_vld;
  logic [`RD_LAT-1:0] tag_rd;     // a real read was issued
  logic [`RD_LAT-1:0] tag_first;  // neighbour 0, restart the count
  logic [`RD_LAT-1:0] tag_last;   // neighbour 8, close the count
  logic [`RD_LAT-1:0] tag_fin;    // centre is the last pixel
  pix_addr_t          tag_addr [`RD_LAT];
  logic [3:0]         cnt;
  logic [3:0]         sum;
  logic               wr_fin;     // current write is the final one

  assign at_left  = (x == '0);
  assign at_right = (x == pix_addr_t'(`IMG_W - 1));
  assign at_top   = (y == '0);
  assign at_bot   = (y == pix_addr_t'(`IMG_H - 1));
  assign last_pix = at_right && at_bot;

  // column of the neighbour, offsets wrap in the address width
  always_comb begin
    col_ok  = 1'b1;
    col_off = '0;
    if (k == 4'd0 || k == 4'd3 || k == 4'd6) begin
      col_ok  = !at_left;
      col_off = '1;                            // minus one
    end else if (k == 4'd2 || k == 4'd5 || k == 4'd8) begin
      col_ok  = !at_right;
      col_off = pix_addr_t'(1);
    end
  end

  // row of the neighbour
  always_comb begin
    row_ok  = 1'b1;
    row_off = '0;
    if (k < 4'd3) begin
      row_ok  = !at_top;
      row_off = pix_addr_t'(0 - `IMG_W);       // one row up
    end else if (k > 4'd5) begin
      row_ok  = !at_bot;
      row_off = pix_addr_t'(`IMG_W);
    end
  end

  // outside neighbours are not read and count as zero
  assign filt_rd_en   = active && row_ok && col_ok;
  assign filt_rd_addr = ctr + row_off + col_off;

  // walker, nine cycles per centre pixel whether read or skipped
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      active <= 1'b0;
      k      <= '0;
      x      <= '0;
      y      <= '0;
      ctr    <= '0;
    end else if (start_pulse) begin
      active <= 1'b1;
      k      <= '0;
      x      <= '0;
      y      <= '0;
      ctr    <= '0;
    end else if (active) begin
      if (k == 4'd8) begin
        k   <= '0;
        ctr <= ctr + pix_addr_t'(1);
        if (at_right) begin
          x <= '0;
          y <= y + pix_addr_t'(1);
          if (at_bot) begin
            active <= 1'b0;     // last neighbour of the last pixel issued
          end
        end else begin
          x <= x + pix_addr_t'(1);
        end
      end else begin
        k <= k + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      tag_vld <= '0;
    end else begin
      tag_vld <= {tag_vld[`RD_LAT-2:0], active};
    end
  end

  always_ff @(posedge clk_pixel) begin
    tag_rd    <= {tag_rd[`RD_LAT-2:0], filt_rd_en};
    tag_first <= {tag_first[`RD_LAT-2:0], (k == 4'd0)};
    tag_last  <= {tag_last[`RD_LAT-2:0], (k == 4'd8)};
    tag_fin   <= {tag_fin[`RD_LAT-2:0], last_pix};
    tag_addr[0] <= ctr;
    for (int i = 1; i < `RD_LAT; i++) begin
      tag_addr[i] <= tag_addr[i-1];
    end
  end

  // running count, next pixel's reads already in flight when it closes
  assign sum = (tag_first[`RD_LAT-1] ? 4'd0 : cnt)
             + {3'b000, tag_rd[`RD_LAT-1] & filt_rd_data};

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      cnt       <= '0;
      res.wr_en <= 1'b0;
      wr_fin    <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (tag_vld[`RD_LAT-1]) begin
        cnt <= sum;
      end
      res.wr_en <= tag_vld[`RD_LAT-1] && tag_last[`RD_LAT-1];
      wr_fin    <= tag_vld[`RD_LAT-1] && tag_last[`RD_LAT-1] && tag_fin[`RD_LAT-1];
      done      <= wr_fin;  // one cycle after the final write
    end
  end

  always_ff @(posedge clk_pixel) begin
    res.wr_addr <= tag_addr[`RD_LAT-1];
    res.wr_data <= (sum >= 4'(`MAJORITY));
  end

endmodule

/* src/pixel_binarizer.sv */
`include "qr_consts.svh"

// rgb 5-6-5 to one bit per pixel, written into the frame buffer
module pixel_binarizer (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  logic                   pix_valid,
  input  qr_pixel_pkg::rgb565_t  pix_data,
  input  qr_pixel_pkg::coord_x_t pix_x,
  input  qr_pixel_pkg::coord_y_t pix_y,
  input  qr_pixel_pkg::thresh_t  thresh,
  input  logic                   store_en,   // STREAMING and capture low
  bit_ram_if.writer              fb
);
  import qr_pixel_pkg::*;
  import qr_mem_pkg::*;

  gray_t              red8;
  gray_t              green8;
  gray_t              blue8;
  logic [`GRAY_W+1:0] gray_sum;    // r + 2g + b, max 1000
  gray_t              gray;
  logic               bin_bit;
  logic               in_frame;
  pix_addr_t          lin_addr;

  // widen each channel to 8 bits, low bits zero
  assign red8   = {pix_data[15:11], 3'b000};
  assign green8 = {pix_data[10:5], 2'b00};
  assign blue8  = {pix_data[4:0], 3'b000};

  assign gray_sum = {2'b00, red8} + {1'b0, green8, 1'b0} + {2'b00, blue8};
  assign gray     = gray_sum[`GRAY_W+1:2];   // divide by 4, truncated
  assign bin_bit  = (gray > thresh);

  // camera coordinates can run past the stored square
  assign in_frame = (pix_x < `X_W'(`IMG_W)) && (pix_y < `Y_W'(`IMG_H));

  // row major, only meaningful when in_frame holds
  assign lin_addr = pix_addr_t'(pix_x) + pix_addr_t'(pix_y * `IMG_W);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      fb.wr_en <= 1'b0;
    end else begin
      fb.wr_en <= pix_valid && store_en && in_frame;  // pixel dropped otherwise
    end
  end

  // payload follows every input, qualified by wr_en
  always_ff @(posedge clk_pixel) begin
    fb.wr_addr <= lin_addr;
    fb.wr_data <= bin_bit;
  end

endmodule

/* src/bit_frame_ram.sv */
`include "qr_consts.svh"

// 1-bit simple dual-port buffer with a two stage registered read
module bit_frame_ram #(
  parameter int DEPTH  = `PIX_N,
  parameter int ADDR_W = $bits(qr_mem_pkg::pix_addr_t)
) (
  input logic    clk_pixel,
  bit_ram_if.mem ram
);

  logic mem [DEPTH];
  logic rd_q;       // first read stage, memory output latch
  logic wr_in_range;

  // writes past a non power of two depth are ignored
  assign wr_in_range = ({1'b0, ram.wr_addr} < (ADDR_W + 1)'(DEPTH));

  // buffer powers up clear, reset leaves the contents alone
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 1'b0;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (ram.wr_en && wr_in_range) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // read first on a same address collision
  always_ff @(posedge clk_pixel) begin
    if (ram.rd_en) begin
      rd_q <= mem[ram.rd_addr];
    end
    ram.rd_data <= rd_q;  // output register, second cycle
  end

endmodule

/* src/bit_ram_if.sv */
`include "qr_consts.svh"

// one write port and one read port of a 1-bit buffer
interface bit_ram_if;
  import qr_mem_pkg::*;

  logic      wr_en;
  pix_addr_t wr_addr;
  logic      wr_data;
  logic      rd_en;
  pix_addr_t rd_addr;
  logic      rd_data;   // valid RD_LAT cycles after rd_en

  // producer of bits, binarizer or filter
  modport writer (output wr_en, wr_addr, wr_data);

  // consumer, the read side is multiplexed in decode_ctrl
  modport reader (output rd_en, rd_addr, input rd_data);

  // memory itself
  modport mem (
    input  wr_en, wr_addr, wr_data,
    input  rd_en, rd_addr,
    output rd_data
  );

endinterface

/* src/qr_mem_pkg.sv */
`include "qr_consts.svh"

package qr_mem_pkg;

  // linear buffer address, x + IMG_W * y
  typedef logic [`ADDR_W-1:0] pix_addr_t;

  // decode sequence, only a reset brings it back to the start
  typedef enum logic [1:0] {
    STREAMING,   // frame buffer follows the camera, display shows it
    AVERAGING,   // filter owns the frame buffer read port
    FINISHED     // both buffers stable, display may pick either
  } decode_state_e;

  // STREAMING  -> AVERAGING  when capture and start are both high
  // AVERAGING  -> FINISHED   on the filter done pulse
  // FINISHED   holds until sys_rst
  //
  // the display is blanked in AVERAGING and when it asks for the
  // result buffer in STREAMING, since that buffer is empty or stale
  // until the first pass has run

endpackage

/* src/qr_pixel_pkg.sv */
`include "qr_consts.svh"

package qr_pixel_pkg;

  // camera pixel, red in [15:11], green in [10:5], blue in [4:0]
  typedef logic [`PIX_W-1:0] rgb565_t;

  // gray level of one pixel
  // red and blue are scaled up by 8 and green by 4 before the sum,
  // so a full white pixel lands close to the top of the range
  typedef logic [`GRAY_W-1:0] gray_t;

  typedef logic [`THRESH_W-1:0] thresh_t;  // bit is set when gray > thresh

  // input coordinates are wider than the stored image,
  // anything past the image edge is dropped by the binarizer
  typedef logic [`X_W-1:0] coord_x_t;
  typedef logic [`Y_W-1:0] coord_y_t;

endpackage

/* src/qr_consts.svh */
`ifndef QR_CONSTS_SVH
`define QR_CONSTS_SVH

// stored image, square and small so that a full decode pass stays short
`define IMG_W 16
`define IMG_H 16
`define PIX_N (`IMG_W * `IMG_H)   // bits held by each buffer
`define ADDR_W $clog2(`PIX_N)     // buffer address width, 8 at 16x16

// camera side widths
`define PIX_W 16                  // rgb 5-6-5 word
`define GRAY_W 8                  // gray level after channel widening
`define THRESH_W 8
`define X_W 11                    // column count from the camera side
`define Y_W 10                    // row count from the camera side

// 3x3 majority, set when this many of the 9 neighbours are one
`define MAJORITY 5

`define RD_LAT 2                  // buffer read latency, rd_en to rd_data

`endif
